// File: common/uart_link_defs.svh
/*
 * Link-wide constants for the string UART.
 * UART_CLKS_PER_BIT must divide evenly and be at least 4.
 * UART_MAX_BYTES must stay below 254 so that the 8-bit length can saturate.
 */
`ifndef UART_LINK_DEFS_SVH
`define UART_LINK_DEFS_SVH

// System clock and line rate
`define UART_CLK_HZ        25_000_000
`define UART_BAUD          1_562_500

`define UART_CLKS_PER_BIT  (`UART_CLK_HZ / `UART_BAUD)   // 16 clocks per bit

// String capacity in bytes, per frame
`define UART_MAX_BYTES     137

// Frame delimiter, ASCII '&'
`define UART_DELIM         8'h26

`endif

// File: common/uart_link_pkg.sv
/*
 * Types shared by the string link and its serial layer.
 * Byte 0 of a string sits in data[7:0].
 */
`include "uart_link_defs.svh"

package uart_link_pkg;

	// String payload plus its length in bytes
	typedef struct packed {
		logic [`UART_MAX_BYTES*8-1:0] data;
		logic [7:0]                   length;
	} tx_frame_t;

	// Received string, same layout as the request
	typedef tx_frame_t rx_frame_t;

	// One byte from the deserializer, valid for a single cycle
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} uart_byte_t;

endpackage

// File: uart_phy/uart_tx.sv
/*
 * 8N2 serializer, LSB first.
 * tx_start is ignored while a byte is in progress.
 * byte_done is high in the last clock of the second stop bit.
 */
`timescale 1ns/10ps
`include "uart_link_defs.svh"

module uart_tx #(
	parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] tx_byte,
	input  logic       tx_start,
	output logic       txd,
	output logic       byte_done
);

	localparam int CW = $clog2(CLKS_PER_BIT + 1);

	logic          busy;
	logic [CW-1:0] clk_cnt;      // Clocks within current bit
	logic [3:0]    bit_idx;      // 0 start, 1..8 data, 9..10 stop
	logic [9:0]    shreg;        // Data then two stop bits
	logic          bit_end;

	assign bit_end   = busy && (clk_cnt == CW'(CLKS_PER_BIT - 1));
	assign byte_done = bit_end && (bit_idx == 4'd10);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
			txd     <= 1'b1;
		end else if (!busy) begin
			if (tx_start) begin
				busy    <= 1'b1;
				clk_cnt <= '0;
				bit_idx <= '0;
				txd     <= 1'b0;   // Start bit on the next edge
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			if (bit_idx == 4'd10) begin
				busy <= 1'b0;
				txd  <= 1'b1;
			end else begin
				bit_idx <= bit_idx + 4'd1;
				txd     <= shreg[0];
			end
		end else begin
			clk_cnt <= clk_cnt + CW'(1);
		end
	end

	// Shift register, refilled on each start
	always_ff @(posedge sys_clk) begin
		if (!busy && tx_start)
			shreg <= {2'b11, tx_byte};
		else if (bit_end)
			shreg <= {1'b1, shreg[9:1]};
	end

endmodule

// File: uart_phy/uart_rx.sv
/*
 * 8N1 deserializer with a two-flop synchronizer.
 * Samples at mid-bit and returns to idle at the middle of the stop bit.
 * A byte with a low stop bit is dropped without any flag.
 */
`timescale 1ns/10ps
`include "uart_link_defs.svh"

module uart_rx import uart_link_pkg::*; #(
	parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rxd,
	output uart_byte_t rx_byte
);

	localparam int CW   = $clog2(CLKS_PER_BIT + 1);
	localparam int HALF = CLKS_PER_BIT / 2;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e     state;
	logic          rx_meta;
	logic          rx_sync;
	logic          rx_prev;     // For falling edge detection
	logic [CW-1:0] clk_cnt;
	logic [2:0]    bit_idx;
	logic [7:0]    shreg;
	logic          valid;
	logic          full_bit;

	assign full_bit = (clk_cnt == CW'(CLKS_PER_BIT - 1));
	assign rx_byte  = '{valid: valid, data: shreg};

	// Line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			valid   <= 1'b0;
		end else begin
			valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (rx_prev && !rx_sync) begin
						state   <= RX_START;
						clk_cnt <= CW'(1);   // Edge cycle already counts
					end
				end
				RX_START: begin
					if (clk_cnt == CW'(HALF - 1)) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? RX_IDLE : RX_DATA;   // Glitch check
					end else begin
						clk_cnt <= clk_cnt + CW'(1);
					end
				end
				RX_DATA: begin
					if (full_bit) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else begin
						clk_cnt <= clk_cnt + CW'(1);
					end
				end
				default: begin   // Stop bit
					if (full_bit) begin
						clk_cnt <= '0;
						state   <= RX_IDLE;
						valid   <= rx_sync;
					end else begin
						clk_cnt <= clk_cnt + CW'(1);
					end
				end
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && full_bit)
			shreg <= {rx_sync, shreg[7:1]};
	end

endmodule

// File: rtl/uart_string_ctrl.sv
/*
 * String link over UART with frames of the form "&&" content "&&".
 * Content must not hold "&&". A lone '&' is kept as data.
 * Lengths above UART_MAX_BYTES are clamped on both sides.
 * No back-pressure. Wait for tx_busy low before the next tx_req.
 */
`timescale 1ns/10ps
`include "uart_link_defs.svh"

module uart_string_ctrl import uart_link_pkg::*; (
	input  logic      sys_clk,
	input  logic      sys_rst_n,
	input  tx_frame_t tx_frame,
	input  logic      tx_req,
	output logic      tx_busy,
	output logic      tx_done,
	output rx_frame_t rx_frame,
	output logic      rx_busy,
	output logic      rx_done,
	input  logic      uart_rx_port,
	output logic      uart_tx_port
);

	localparam logic [7:0] DELIM   = `UART_DELIM;
	localparam logic [7:0] MAX_LEN = 8'(`UART_MAX_BYTES);

	typedef enum logic [2:0] {
		TX_IDLE, TX_OPEN, TX_CONTENT, TX_CLOSE, TX_FINISH
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_HUNT, RX_FIRST, RX_CONTENT, RX_PEND, RX_FINISH
	} rx_state_e;

	tx_state_e  tx_state, tx_state_nxt;
	logic [7:0] tx_cnt, tx_cnt_nxt;   // Bytes sent in current state
	logic       tx_accept;
	logic       tx_send;
	logic [7:0] tx_next;
	logic       tx_start;
	logic [7:0] tx_byte;
	logic       byte_done;
	tx_frame_t  tx_frame_q;

	rx_state_e  rx_state;
	uart_byte_t rx_byte;
	logic       is_delim;

	assign tx_accept = tx_req && (tx_state == TX_IDLE || tx_state == TX_FINISH);
	assign tx_busy   = (tx_state != TX_IDLE) && (tx_state != TX_FINISH);
	assign tx_done   = (tx_state == TX_FINISH);

	// Next byte choice on each byte_done
	always_comb begin
		tx_state_nxt = tx_state;
		tx_cnt_nxt   = tx_cnt;
		tx_send      = 1'b0;
		tx_next      = DELIM;
		case (tx_state)
			TX_IDLE, TX_FINISH: begin
				tx_state_nxt = TX_IDLE;
				if (tx_accept) begin
					tx_state_nxt = TX_OPEN;
					tx_cnt_nxt   = 8'd0;
					tx_send      = 1'b1;
				end
			end
			TX_OPEN: begin
				if (byte_done) begin
					tx_send = 1'b1;
					if (tx_cnt == 8'd0) begin
						tx_cnt_nxt = 8'd1;   // Second '&'
					end else if (tx_frame_q.length == 8'd0) begin
						tx_state_nxt = TX_CLOSE;
						tx_cnt_nxt   = 8'd0;
					end else begin
						tx_state_nxt = TX_CONTENT;
						tx_next      = tx_frame_q.data[7:0];
						tx_cnt_nxt   = 8'd1;
					end
				end
			end
			TX_CONTENT: begin
				if (byte_done) begin
					tx_send = 1'b1;
					if (tx_cnt == tx_frame_q.length) begin
						tx_state_nxt = TX_CLOSE;
						tx_cnt_nxt   = 8'd0;
					end else begin
						tx_next    = tx_frame_q.data[8*tx_cnt +: 8];
						tx_cnt_nxt = tx_cnt + 8'd1;
					end
				end
			end
			TX_CLOSE: begin
				if (byte_done) begin
					if (tx_cnt == 8'd0) begin
						tx_send    = 1'b1;
						tx_cnt_nxt = 8'd1;
					end else begin
						tx_state_nxt = TX_FINISH;
					end
				end
			end
			default: tx_state_nxt = TX_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state <= TX_IDLE;
			tx_cnt   <= 8'd0;
			tx_start <= 1'b0;
		end else begin
			tx_state <= tx_state_nxt;
			tx_cnt   <= tx_cnt_nxt;
			tx_start <= tx_send;
		end
	end

	// Request is sampled once, on acceptance
	always_ff @(posedge sys_clk) begin
		if (tx_accept) begin
			tx_frame_q.data   <= tx_frame.data;
			tx_frame_q.length <= (tx_frame.length > MAX_LEN) ? MAX_LEN : tx_frame.length;
		end
		if (tx_send)
			tx_byte <= tx_next;
	end

	assign is_delim = (rx_byte.data == DELIM);
	assign rx_busy  = (rx_state == RX_CONTENT) || (rx_state == RX_PEND);
	assign rx_done  = (rx_state == RX_FINISH);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state <= RX_HUNT;
		end else begin
			case (rx_state)
				RX_HUNT:
					if (rx_byte.valid && is_delim) rx_state <= RX_FIRST;
				RX_FIRST:
					if (rx_byte.valid) rx_state <= is_delim ? RX_CONTENT : RX_HUNT;
				RX_CONTENT:
					if (rx_byte.valid && is_delim) rx_state <= RX_PEND;
				RX_PEND:   // Second '&' closes, anything else is content
					if (rx_byte.valid) rx_state <= is_delim ? RX_FINISH : RX_CONTENT;
				default: rx_state <= RX_HUNT;
			endcase
		end
	end

	// Saturating store, extra bytes are dropped
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_frame <= '0;
		end else if (rx_byte.valid) begin
			case (rx_state)
				RX_FIRST: begin
					if (is_delim)
						rx_frame.length <= 8'd0;
				end
				RX_CONTENT: begin
					if (!is_delim && rx_frame.length < MAX_LEN) begin
						rx_frame.data[8*rx_frame.length +: 8] <= rx_byte.data;
						rx_frame.length                       <= rx_frame.length + 8'd1;
					end
				end
				RX_PEND: begin
					if (!is_delim) begin
						if (rx_frame.length < MAX_LEN)
							rx_frame.data[8*rx_frame.length +: 8] <= DELIM;   // Held '&'
						if (rx_frame.length < MAX_LEN - 8'd1)
							rx_frame.data[8*rx_frame.length + 8 +: 8] <= rx_byte.data;
						rx_frame.length <= (rx_frame.length < MAX_LEN - 8'd1) ?
							rx_frame.length + 8'd2 : MAX_LEN;
					end
				end
				default: ;
			endcase
		end
	end

	uart_tx #(
		.CLKS_PER_BIT (`UART_CLKS_PER_BIT)
	) uart_tx_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_byte   (tx_byte),
		.tx_start  (tx_start),
		.txd       (uart_tx_port),
		.byte_done (byte_done)
	);

	uart_rx #(
		.CLKS_PER_BIT (`UART_CLKS_PER_BIT)
	) uart_rx_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rx_port),
		.rx_byte   (rx_byte)
	);

endmodule

// File: testbench/tb_uart_string_ctrl.sv
/*
 * Testbench for uart_string_ctrl, driven by testbench/uart_link_vectors.txt.
 * Run from the project root so that the vector path resolves.
 * Hex content holds at most 64 bytes, longer strings use the letter pattern.
 */
`timescale 1ns/10ps
`include "uart_link_defs.svh"

module tb_uart_string_ctrl
	import uart_link_pkg::*;
();

	localparam int         CPB     = `UART_CLKS_PER_BIT;
	localparam int         MAX_VEC = 16;
	localparam logic [7:0] DELIM   = `UART_DELIM;

	logic      sys_clk;
	logic      sys_rst_n;
	tx_frame_t tx_frame;
	logic      tx_req;
	logic      tx_busy;
	logic      tx_done;
	rx_frame_t rx_frame;
	logic      rx_busy;
	logic      rx_done;
	logic      uart_rx_port;
	logic      uart_tx_port;

	logic [7:0]   vec_dir [0:MAX_VEC-1];
	logic [7:0]   vec_src [0:MAX_VEC-1];
	int           vec_len [0:MAX_VEC-1];
	int           vec_bad [0:MAX_VEC-1];
	int           vec_exp [0:MAX_VEC-1];
	logic [511:0] vec_hex [0:MAX_VEC-1];
	int           n_vec = 0;

	logic [7:0]  tx_seen[$];            // Bytes decoded from uart_tx_port
	logic [31:0] rng_state   = 32'h8597bcfb;
	int          tx_done_cnt = 0;
	int          rx_done_cnt = 0;
	int          cycle_cnt   = 0;
	int          cycle_limit = 0;       // Zero until the vectors are known
	int          checks      = 0;
	int          errors      = 0;

	uart_string_ctrl uart_string_ctrl_i (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_frame     (tx_frame),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_frame     (rx_frame),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	always #20 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (tx_done)
			tx_done_cnt <= tx_done_cnt + 1;
		if (rx_done)
			rx_done_cnt <= rx_done_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
			$display("Run timed out after %0d cycles", cycle_cnt);
			$display("Checks run: %0d, errors: %0d", checks, errors);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
		input string what);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("FAILED at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
		end
	endtask

	task automatic next_cycle();
		@(posedge sys_clk);
		#2;
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Random filler byte that is never a delimiter
	task automatic noise_byte(output logic [7:0] b);
		b = DELIM;
		while (b == DELIM) begin
			rng_state = lcg_next(rng_state);
			b = rng_state[23:16];
		end
	endtask

	function automatic logic [7:0] content_byte(input int v, input int idx);
		if (vec_src[v] == "P")
			return 8'h41 + 8'(idx % 26);   // A to Z, repeating
		return vec_hex[v][8*(vec_len[v]-1-idx) +: 8];
	endfunction

	task automatic read_vectors(output bit ok);
		int fd;
		int code;
		int len;
		int bad;
		int exp_len;
		logic [7:0] dir;
		logic [7:0] src;
		logic [511:0] hex;
		logic [8*160-1:0] skip;
		fd = $fopen("testbench/uart_link_vectors.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			code = $fscanf(fd, " %c", dir);
			while (code == 1 && n_vec < MAX_VEC) begin
				if (dir == "#") begin
					code = $fgets(skip, fd);
				end else begin
					code = $fscanf(fd, "%d %d %d %c %h", len, bad, exp_len, src, hex);
					vec_dir[n_vec] = dir;
					vec_len[n_vec] = len;
					vec_bad[n_vec] = bad;
					vec_exp[n_vec] = exp_len;
					vec_src[n_vec] = src;
					vec_hex[n_vec] = hex;
					cycle_limit += 2 * (len + 12) * 12 * CPB;   // Worst case, doubled
					n_vec++;
				end
				code = $fscanf(fd, " %c", dir);
			end
			$fclose(fd);
			cycle_limit += 20;
		end
	endtask

	task automatic drive_bit(input logic v);
		uart_rx_port = v;
		repeat (CPB) @(posedge sys_clk);
		#2;
	endtask

	// 8N1 byte, a bad stop bit is followed by one idle bit
	task automatic send_serial_byte(input logic [7:0] b, input logic stop_ok);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
			drive_bit(b[i]);
		drive_bit(stop_ok);
		if (!stop_ok)
			drive_bit(1'b1);
	endtask

	initial begin : tx_monitor
		logic [7:0] b;
		int i;
		wait (sys_rst_n === 1'b1);
		forever begin
			@(negedge uart_tx_port);
			repeat (CPB / 2) @(posedge sys_clk);   // Middle of the start bit
			for (i = 0; i < 8; i++) begin
				repeat (CPB) @(posedge sys_clk);
				b[i] = uart_tx_port;
			end
			repeat (CPB) @(posedge sys_clk);
			check_value(1, uart_tx_port, "tx stop bit");
			tx_seen.push_back(b);
		end
	end

	task automatic run_tx_vector(input int v);
		logic [7:0] exp_q[$];
		int done_before;
		int busy_low;
		int cyc;
		int i;
		done_before = tx_done_cnt;
		busy_low    = 0;
		tx_seen.delete();
		tx_frame        = '0;
		tx_frame.length = 8'(vec_len[v]);
		for (i = 0; i < vec_len[v] && i < `UART_MAX_BYTES; i++)
			tx_frame.data[8*i +: 8] = content_byte(v, i);
		exp_q.push_back(DELIM);
		exp_q.push_back(DELIM);
		for (i = 0; i < vec_exp[v]; i++)
			exp_q.push_back(content_byte(v, i));
		exp_q.push_back(DELIM);
		exp_q.push_back(DELIM);
		tx_req = 1'b1;
		next_cycle();
		tx_req = 1'b0;
		cyc = 0;
		while (!tx_done) begin
			if (!tx_busy)
				busy_low++;
			if (cyc == 40) begin   // New data and a request that must be ignored
				tx_frame.data   = ~tx_frame.data;
				tx_frame.length = 8'd3;
				tx_req          = 1'b1;
			end else begin
				tx_req = 1'b0;
			end
			cyc++;
			next_cycle();
		end
		repeat (2 * 11 * CPB) next_cycle();   // Line must stay idle
		check_value(0, busy_low, "cycles with tx_busy low during frame");
		check_value(done_before + 1, tx_done_cnt, "tx_done pulse count");
		check_value(0, tx_busy, "tx_busy after frame");
		check_value(exp_q.size(), tx_seen.size(), "line byte count");
		for (i = 0; i < exp_q.size(); i++)
			check_value(exp_q[i], tx_seen[i], $sformatf("line byte %0d", i));
	endtask

	task automatic run_rx_vector(input int v);
		logic [7:0] exp_q[$];
		logic [7:0] b;
		int done_before;
		int i;
		done_before = rx_done_cnt;
		repeat (3) begin
			noise_byte(b);
			send_serial_byte(b, 1'b1);
		end
		send_serial_byte(DELIM, 1'b1);   // Lone delimiter before the frame
		noise_byte(b);
		send_serial_byte(b, 1'b1);
		send_serial_byte(DELIM, 1'b1);
		send_serial_byte(DELIM, 1'b1);
		check_value(1, rx_busy, "rx_busy after opening delimiter");
		check_value(0, rx_frame.length, "received length cleared on open");
		for (i = 0; i < vec_len[v]; i++) begin
			b = content_byte(v, i);
			send_serial_byte(b, i != vec_bad[v]);
			if (i != vec_bad[v])
				exp_q.push_back(b);
		end
		send_serial_byte(DELIM, 1'b1);
		send_serial_byte(DELIM, 1'b1);
		while (rx_done_cnt == done_before)
			next_cycle();
		check_value(done_before + 1, rx_done_cnt, "rx_done pulse count");
		check_value(0, rx_busy, "rx_busy after frame");
		check_value(vec_exp[v], rx_frame.length, "received length");
		for (i = 0; i < vec_exp[v]; i++)
			check_value(exp_q[i], rx_frame.data[8*i +: 8], $sformatf("received byte %0d", i));
	endtask

	initial begin : main
		bit ok;
		int v;
		sys_clk      = 1'b0;
		sys_rst_n    = 1'b0;
		tx_req       = 1'b0;
		tx_frame     = '0;
		uart_rx_port = 1'b1;
		read_vectors(ok);
		if (!ok) begin
			$display("Could not open testbench/uart_link_vectors.txt");
			$display("RESULT: FAIL");
			$finish;
		end else begin
			repeat (10) @(posedge sys_clk);
			#2;
			sys_rst_n = 1'b1;
			next_cycle();
			check_value(1, uart_tx_port, "idle uart_tx_port");
			check_value(0, {tx_busy, tx_done, rx_busy, rx_done}, "status after reset");
			check_value(1, rx_frame === '0, "rx_frame cleared by reset");
			if (n_vec == 0) begin
				$display("No test vectors found in the vector file");
				errors++;
			end
			for (v = 0; v < n_vec; v++) begin
				if (vec_dir[v] == "T")
					run_tx_vector(v);
				else
					run_rx_vector(v);
			end
			$display("Checks run: %0d, errors: %0d", checks, errors);
			if (errors == 0)
				$display("RESULT: PASS");
			else
				$display("RESULT: FAIL");
			$finish;
		end
	end

endmodule

// File: files.f
+incdir+common
common/uart_link_pkg.sv
uart_phy/uart_tx.sv
uart_phy/uart_rx.sv
rtl/uart_string_ctrl.sv
testbench/tb_uart_string_ctrl.sv

// File: testbench/uart_link_vectors.txt
# dir len bad exp src content: T sends from the DUT, R drives the DUT serial input
# bad is a content index sent with a low stop bit (-1 none), src H hex or P letter pattern
T 0 -1 0 H 0
T 1 -1 1 H 41
T 5 -1 5 H 48656c6c6f
T 3 -1 3 H 412642
T 137 -1 137 P 0
R 5 -1 5 H 576f726c64
R 4 -1 4 H 41264263
R 3 -1 3 H 262178
R 0 -1 0 H 0
R 150 -1 137 P 0
R 6 2 5 H 537472696e67
